/* lwc_params.svh */
`ifndef LWC_PARAMS_SVH
`define LWC_PARAMS_SVH

// data path widths
`define LWC_W             32
`define LWC_BLK_WORDS     4
`define LWC_BLK_BYTES     16

// word counter and round constant LFSR
`define LWC_RC_W          6
`define LWC_RC_INIT       6'h01
`define LWC_RC_LAST_WORD  6'h0F
`define LWC_RC_FINAL      6'h1A

// segment length field of a header word
`define LWC_LEN_W         16

`endif

/* lwc_pkg.sv */
`default_nettype none
`include "lwc_params.svh"

package lwc_pkg;

   typedef enum logic [3:0] {
      op_enc     = 4'd2,
      op_ldkey   = 4'd4,
      op_actkey  = 4'd7,
      op_success = 4'd14
   } opcode_t;

   typedef enum logic [3:0] {
      seg_ad     = 4'd1,
      seg_plain  = 4'd4,
      seg_cipher = 4'd5,
      seg_tag    = 4'd8,
      seg_key    = 4'd12,
      seg_npub   = 4'd13
   } seg_type_t;

   typedef enum logic [7:0] {
      dom_none       = 8'd0,   // nonce block
      dom_msg_normal = 8'd4,
      dom_ad_normal  = 8'd8,
      dom_msg_final  = 8'd20,
      dom_msg_padded = 8'd21,
      dom_ad_final   = 8'd24,
      dom_ad_padded  = 8'd26
   } domain_t;

   typedef enum logic [2:0] {
      sel_none,
      sel_cipher_hdr,
      sel_cipher,
      sel_tag_hdr,
      sel_tag,
      sel_status
   } out_sel_t;

   typedef enum logic [4:0] {
      st_idle,
      st_ldkey,
      st_key_hdr,
      st_key_store,
      st_ad_hdr,
      st_ad_store,
      st_npub_hdr,
      st_npub_store,
      st_msg_hdr,
      st_msg_store,
      st_rounds,
      st_tag_hdr,
      st_tag_words,
      st_status
   } ctrl_state_t;

   // one LFSR step, xnor feedback
   function automatic logic [`LWC_RC_W-1:0] rc_step(input logic [`LWC_RC_W-1:0] c);
      return {c[`LWC_RC_W-2:0], ~(c[`LWC_RC_W-1] ^ c[`LWC_RC_W-2])};
   endfunction

   // LFSR value to word position inside a block
   function automatic logic [1:0] word_pos(input logic [`LWC_RC_W-1:0] c);
      case (c)
         6'h03:   return 2'd1;
         6'h07:   return 2'd2;
         6'h0F:   return 2'd3;
         default: return 2'd0;
      endcase
   endfunction

endpackage

`default_nettype wire

/* lwc_api_ctrl.sv */
`default_nettype none
`include "lwc_params.svh"

module lwc_api_ctrl (
   input  wire                   clk,
   input  wire                   rst,
   input  wire  [`LWC_W-1:0]     pdi_hdr,
   input  wire                   pdi_valid,
   input  wire  [`LWC_W-1:0]     sdi_hdr,
   input  wire                   sdi_valid,
   input  wire                   pdo_ready,
   output logic                  pdi_ready,
   output logic                  sdi_ready,
   output logic                  pdo_valid,
   output logic                  do_last,
   output logic                  key_we,
   output logic                  absorb_we,
   output logic                  init_state,
   output logic                  round_en,
   output logic [`LWC_RC_W-1:0]  word_idx,
   output logic                  pad_mode,
   output logic [3:0]            pad_len,
   output lwc_pkg::domain_t      domain,
   output lwc_pkg::out_sel_t     out_sel,
   output logic [2:0]            valid_bytes
);
   import lwc_pkg::*;

   ctrl_state_t           fsm;
   ctrl_state_t           fsm_nxt;
   ctrl_state_t           ret;
   ctrl_state_t           ret_nxt;
   ctrl_state_t           blk_ret;
   logic [`LWC_RC_W-1:0]  cnt;
   logic [`LWC_RC_W-1:0]  cnt_nxt;
   logic [`LWC_LEN_W-1:0] seg_len;
   logic [`LWC_LEN_W-1:0] seg_len_nxt;
   logic [`LWC_LEN_W-1:0] len_rest;
   logic [`LWC_LEN_W-1:0] byte_off;
   logic [`LWC_LEN_W-1:0] bytes_left;
   logic                  seg_last;
   logic                  seg_last_nxt;
   logic                  need_word;
   logic                  pad_blk;
   logic                  final_blk;
   logic                  last_word;

   assign byte_off   = `LWC_LEN_W'(word_pos(cnt)) << 2;
   assign bytes_left = seg_len - byte_off;
   assign need_word  = seg_len > byte_off;    // word still carries data
   assign pad_blk    = seg_len < `LWC_BLK_BYTES;
   assign len_rest   = pad_blk ? '0 : seg_len - `LWC_LEN_W'(`LWC_BLK_BYTES);
   assign final_blk  = seg_last && (len_rest == '0);
   assign last_word  = cnt == `LWC_RC_LAST_WORD;
   assign word_idx   = cnt;
   assign pad_len    = seg_len[3:0];

   always_ff @(posedge clk) begin
      if (rst) begin
         fsm      <= st_idle;
         ret      <= st_idle;
         cnt      <= `LWC_RC_INIT;
         seg_len  <= '0;
         seg_last <= 1'b0;
      end else begin
         fsm      <= fsm_nxt;
         ret      <= ret_nxt;
         cnt      <= cnt_nxt;
         seg_len  <= seg_len_nxt;
         seg_last <= seg_last_nxt;
      end
   end

   always_comb begin
      fsm_nxt      = fsm;
      ret_nxt      = ret;
      cnt_nxt      = cnt;
      seg_len_nxt  = seg_len;
      seg_last_nxt = seg_last;
      blk_ret      = st_idle;
      pdi_ready    = 1'b0;
      sdi_ready    = 1'b0;
      pdo_valid    = 1'b0;
      do_last      = 1'b0;
      key_we       = 1'b0;
      absorb_we    = 1'b0;
      init_state   = 1'b0;
      round_en     = 1'b0;
      pad_mode     = 1'b0;
      domain       = dom_none;
      out_sel      = sel_none;
      valid_bytes  = 3'd4;
      case (fsm)
         st_idle: begin
            pdi_ready = pdi_valid;
            if (pdi_valid) begin
               if (pdi_hdr[31:28] == op_actkey) begin
                  fsm_nxt = st_ldkey;
               end else if (pdi_hdr[31:28] == op_enc) begin
                  init_state = 1'b1;
                  fsm_nxt    = st_ad_hdr;
               end
            end
         end
         st_ldkey: begin
            sdi_ready = sdi_valid;
            if (sdi_valid && sdi_hdr[31:28] == op_ldkey) begin
               fsm_nxt = st_key_hdr;
            end
         end
         st_key_hdr: begin
            sdi_ready = sdi_valid;
            if (sdi_valid && sdi_hdr[31:28] == seg_key) begin
               fsm_nxt = st_key_store;
            end
         end
         st_key_store: begin
            sdi_ready = sdi_valid;
            key_we    = sdi_valid;
            if (sdi_valid) begin
               if (last_word) begin
                  cnt_nxt = `LWC_RC_INIT;
                  fsm_nxt = st_idle;
               end else begin
                  cnt_nxt = rc_step(cnt);
               end
            end
         end
         st_ad_hdr, st_npub_hdr: begin
            pdi_ready = pdi_valid;
            if (pdi_valid) begin
               if (fsm == st_ad_hdr) begin
                  seg_len_nxt  = pdi_hdr[15:0];
                  seg_last_nxt = pdi_hdr[25];
                  fsm_nxt      = st_ad_store;
               end else begin
                  fsm_nxt = st_npub_store;
               end
            end
         end
         st_ad_store: begin
            pad_mode  = pad_blk;
            domain    = pad_blk ? dom_ad_padded : final_blk ? dom_ad_final : dom_ad_normal;
            pdi_ready = need_word && pdi_valid;
            absorb_we = need_word ? pdi_valid : 1'b1;    // padding words need no input
            blk_ret   = (len_rest == '0) ? st_npub_hdr : st_ad_store;
         end
         st_npub_store: begin
            pdi_ready = pdi_valid;
            absorb_we = pdi_valid;
            blk_ret   = st_msg_hdr;
         end
         st_msg_hdr: begin
            out_sel   = sel_cipher_hdr;
            pdo_valid = pdi_valid;
            pdi_ready = pdi_valid && pdo_ready;
            if (pdi_ready) begin
               seg_len_nxt  = pdi_hdr[15:0];
               seg_last_nxt = pdi_hdr[25];
               fsm_nxt      = st_msg_store;
            end
         end
         st_msg_store: begin
            pad_mode    = pad_blk;
            domain      = pad_blk ? dom_msg_padded : final_blk ? dom_msg_final : dom_msg_normal;
            out_sel     = sel_cipher;
            valid_bytes = (bytes_left > 3) ? 3'd4 : bytes_left[2:0];
            pdo_valid   = need_word && pdi_valid;
            pdi_ready   = need_word && pdi_valid && pdo_ready;
            absorb_we   = need_word ? pdi_ready : 1'b1;
            blk_ret     = (len_rest == '0) ? st_tag_hdr : st_msg_store;
         end
         st_rounds: begin
            round_en = 1'b1;
            if (cnt == `LWC_RC_FINAL) begin
               cnt_nxt = `LWC_RC_INIT;
               fsm_nxt = ret;
            end else begin
               cnt_nxt = rc_step(cnt);
            end
         end
         st_tag_hdr: begin
            out_sel   = sel_tag_hdr;
            pdo_valid = 1'b1;
            if (pdo_ready) begin
               fsm_nxt = st_tag_words;
            end
         end
         st_tag_words: begin
            out_sel   = sel_tag;
            pdo_valid = 1'b1;
            if (pdo_ready) begin
               if (last_word) begin
                  cnt_nxt = `LWC_RC_INIT;
                  fsm_nxt = st_status;
               end else begin
                  cnt_nxt = rc_step(cnt);
               end
            end
         end
         st_status: begin
            out_sel   = sel_status;
            pdo_valid = 1'b1;
            do_last   = 1'b1;
            if (pdo_ready) begin
               fsm_nxt = st_idle;
            end
         end
         default: begin
            fsm_nxt = st_idle;
         end
      endcase

      // block word taken, last one starts the rounds
      if (absorb_we) begin
         if (last_word) begin
            cnt_nxt     = `LWC_RC_INIT;
            seg_len_nxt = len_rest;
            ret_nxt     = blk_ret;
            fsm_nxt     = st_rounds;
         end else begin
            cnt_nxt = rc_step(cnt);
         end
      end
   end

endmodule

`default_nettype wire

/* lwc_state_core.sv */
`default_nettype none
`include "lwc_params.svh"

module lwc_state_core (
   input  wire                  clk,
   input  wire                  rst,
   input  wire                  key_we,
   input  wire [`LWC_W-1:0]     key_word,
   input  wire                  absorb_we,
   input  wire                  init_state,
   input  wire                  round_en,
   input  wire [`LWC_RC_W-1:0]  word_idx,
   input  wire [`LWC_RC_W-1:0]  rc,
   input  wire                  pad_mode,
   input  wire [3:0]            pad_len,
   input  wire [`LWC_W-1:0]     in_word,
   input  wire lwc_pkg::domain_t domain,
   output logic [`LWC_W-1:0]    state_word
);
   import lwc_pkg::*;

   localparam int BLK_W = `LWC_W * `LWC_BLK_WORDS;

   logic [BLK_W-1:0]  key_q;
   logic [BLK_W-1:0]  state_q;
   logic [BLK_W-1:0]  blk_q;
   logic [BLK_W-1:0]  absorb_blk;
   logic [BLK_W-1:0]  rc_mask;
   logic [`LWC_W-1:0] pad_word;
   logic [1:0]        pos;

   assign pos = word_pos(word_idx);

   always_comb begin
      pad_word = in_word;
      for (int b = 0; b < 4; b++) begin
         if (pad_mode && (int'(pos) * 4 + b >= int'(pad_len))) begin
            pad_word[31-8*b -: 8] = 8'h00;
         end
      end
      if (pad_mode && pos == 2'd3) begin
         pad_word[3:0] = pad_len;    // byte count in last nibble
      end
   end

   // words 0..2 come from the buffer, word 3 is the current one
   assign absorb_blk = {blk_q[BLK_W-1 -: BLK_W-`LWC_W], pad_word} ^ BLK_W'(domain);
   assign rc_mask    = {8'(rc), {(BLK_W-8){1'b0}}};

   always_ff @(posedge clk) begin
      if (key_we) begin
         key_q[BLK_W-1-`LWC_W*pos -: `LWC_W] <= key_word;
      end
      if (absorb_we) begin
         blk_q[BLK_W-1-`LWC_W*pos -: `LWC_W] <= pad_word;
      end
   end

   always_ff @(posedge clk) begin
      if (rst || init_state) begin
         state_q <= '0;
      end else if (absorb_we && pos == 2'd3) begin
         state_q <= state_q ^ absorb_blk;
      end else if (round_en) begin
         state_q <= {state_q[BLK_W-9:0], state_q[BLK_W-1 -: 8]} ^ key_q ^ rc_mask;
      end
   end

   assign state_word = state_q[BLK_W-1-`LWC_W*pos -: `LWC_W];    // state before absorb

endmodule

`default_nettype wire

/* lwc_out_format.sv */
`default_nettype none
`include "lwc_params.svh"

module lwc_out_format (
   input  wire lwc_pkg::out_sel_t out_sel,
   input  wire [`LWC_W-1:0]       in_word,
   input  wire [`LWC_W-1:0]       state_word,
   input  wire [2:0]              valid_bytes,
   output logic [`LWC_W-1:0]      pdo_data
);
   import lwc_pkg::*;

   logic [`LWC_W-1:0] byte_mask;
   logic [`LWC_W-1:0] ct_word;

   always_comb begin
      byte_mask = '0;
      for (int b = 0; b < 4; b++) begin
         if (b < int'(valid_bytes)) begin
            byte_mask[31-8*b -: 8] = 8'hff;    // msb byte first
         end
      end
   end

   assign ct_word = (in_word ^ state_word) & byte_mask;

   always_comb begin
      case (out_sel)
         sel_cipher_hdr: pdo_data = {seg_cipher, in_word[27:24], 8'h00, in_word[15:0]};
         sel_cipher:     pdo_data = ct_word;
         sel_tag_hdr:    pdo_data = {seg_tag, 4'h3, 8'h00, 16'(`LWC_BLK_BYTES)};
         sel_tag:        pdo_data = state_word;
         sel_status:     pdo_data = {op_success, 28'h0};
         default:        pdo_data = '0;
      endcase
   end

endmodule

`default_nettype wire

/* lwc_api_top.sv */
`default_nettype none
`include "lwc_params.svh"

module lwc_api_top (
   input  wire                 clk,
   input  wire                 rst,
   input  wire  [`LWC_W-1:0]   pdi_data,
   input  wire                 pdi_valid,
   output logic                pdi_ready,
   input  wire  [`LWC_W-1:0]   sdi_data,
   input  wire                 sdi_valid,
   output logic                sdi_ready,
   output logic [`LWC_W-1:0]   pdo_data,
   output logic                pdo_valid,
   input  wire                 pdo_ready,
   output logic                do_last
);
   import lwc_pkg::*;

   logic                 key_we;
   logic                 absorb_we;
   logic                 init_state;
   logic                 round_en;
   logic                 pad_mode;
   logic [`LWC_RC_W-1:0] word_idx;
   logic [3:0]           pad_len;
   logic [2:0]           valid_bytes;
   logic [`LWC_W-1:0]    state_word;
   domain_t              domain;
   out_sel_t             out_sel;

   lwc_api_ctrl u_ctrl (
      .clk         (clk),
      .rst         (rst),
      .pdi_hdr     (pdi_data),
      .pdi_valid   (pdi_valid),
      .sdi_hdr     (sdi_data),
      .sdi_valid   (sdi_valid),
      .pdo_ready   (pdo_ready),
      .pdi_ready   (pdi_ready),
      .sdi_ready   (sdi_ready),
      .pdo_valid   (pdo_valid),
      .do_last     (do_last),
      .key_we      (key_we),
      .absorb_we   (absorb_we),
      .init_state  (init_state),
      .round_en    (round_en),
      .word_idx    (word_idx),
      .pad_mode    (pad_mode),
      .pad_len     (pad_len),
      .domain      (domain),
      .out_sel     (out_sel),
      .valid_bytes (valid_bytes)
   );

   // word counter doubles as round constant
   lwc_state_core u_core (
      .clk         (clk),
      .rst         (rst),
      .key_we      (key_we),
      .key_word    (sdi_data),
      .absorb_we   (absorb_we),
      .init_state  (init_state),
      .round_en    (round_en),
      .word_idx    (word_idx),
      .rc          (word_idx),
      .pad_mode    (pad_mode),
      .pad_len     (pad_len),
      .in_word     (pdi_data),
      .domain      (domain),
      .state_word  (state_word)
   );

   lwc_out_format u_fmt (
      .out_sel     (out_sel),
      .in_word     (pdi_data),
      .state_word  (state_word),
      .valid_bytes (valid_bytes),
      .pdo_data    (pdo_data)
   );

endmodule

`default_nettype wire

/* lwc_api_assertions.sv */
`default_nettype none

module lwc_api_assertions (
   input wire clk,
   input wire rst,
   input wire pdo_valid,
   input wire pdo_ready,
   input wire do_last,
   input wire pdi_ready,
   input wire sdi_ready
);
   timeunit 1ns;
   timeprecision 1ps;

   // an offered output word waits for pdo_ready
   pdo_hold: assert property (@(posedge clk) disable iff (rst)
      pdo_valid && !pdo_ready |=> pdo_valid)
      else $error("pdo_valid dropped before pdo_ready");

   reset_quiet: assert property (@(posedge clk) rst |-> !pdo_valid && !do_last)
      else $error("pdo_valid or do_last high during reset");

   ready_exclusive: assert property (@(posedge clk) !(pdi_ready && sdi_ready))
      else $error("pdi_ready and sdi_ready high together");

endmodule

bind lwc_api_top lwc_api_assertions u_assertions (
   .clk       (clk),
   .rst       (rst),
   .pdo_valid (pdo_valid),
   .pdo_ready (pdo_ready),
   .do_last   (do_last),
   .pdi_ready (pdi_ready),
   .sdi_ready (sdi_ready)
);

`default_nettype wire

/* lwc_api_tb.sv */
`default_nettype none
`include "lwc_params.svh"

module lwc_api_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int NUM_RUNS       = 12;
   localparam int KEY_LOADS      = 2;
   localparam int CYCLES_PER_RUN = 2000;

   logic        clk;
   logic        rst;
   logic [31:0] pdi_data;
   logic        pdi_valid;
   logic        pdi_ready;
   logic [31:0] sdi_data;
   logic        sdi_valid;
   logic        sdi_ready;
   logic [31:0] pdo_data;
   logic        pdo_valid;
   logic        pdo_ready;
   logic        do_last;

   integer       seed;
   logic [127:0] key_m;
   logic [127:0] nonce_m;
   logic [7:0]   ad_bytes[48];
   logic [7:0]   msg_bytes[48];
   logic [31:0]  in_q[$];
   logic [31:0]  exp_q[$];

   lwc_api_top UUT (
      .clk       (clk),
      .rst       (rst),
      .pdi_data  (pdi_data),
      .pdi_valid (pdi_valid),
      .pdi_ready (pdi_ready),
      .sdi_data  (sdi_data),
      .sdi_valid (sdi_valid),
      .sdi_ready (sdi_ready),
      .pdo_data  (pdo_data),
      .pdo_valid (pdo_valid),
      .pdo_ready (pdo_ready),
      .do_last   (do_last)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial begin
      repeat (CYCLES_PER_RUN * (NUM_RUNS + KEY_LOADS)) @(posedge clk);
      $display("timeout: the DUT stopped answering before all runs were done");
      $display("test failed");
      $fatal(1, "watchdog expired");
   end

   function automatic int rand_below(input int n);
      logic [31:0] r;
      r = $random(seed);
      return int'(r % 32'(n));
   endfunction

   function automatic logic [5:0] next_rc(input logic [5:0] c);
      return {c[4:0], c[5] ~^ c[4]};
   endfunction

   // rotate by a byte, add key and constant until the final constant
   function automatic logic [127:0] run_rounds(input logic [127:0] s, input logic [127:0] k);
      logic [5:0] rc;
      logic       done;
      rc   = `LWC_RC_INIT;
      done = 1'b0;
      for (int i = 0; i < 64; i++) begin
         if (!done) begin
            s = {s[119:0], s[127:120]} ^ k ^ {2'b00, rc, 120'd0};
            if (rc == `LWC_RC_FINAL) done = 1'b1;
            else rc = next_rc(rc);
         end
      end
      return s;
   endfunction

   function automatic logic [127:0] raw_block(input bit is_msg, input int off);
      logic [127:0] b;
      for (int i = 0; i < 16; i++) begin
         b[127-8*i -: 8] = is_msg ? msg_bytes[off+i] : ad_bytes[off+i];
      end
      return b;
   endfunction

   function automatic logic [127:0] pad_block(input logic [127:0] raw, input int n);
      logic [127:0] b;
      b = raw;
      if (n < 16) begin
         for (int i = n; i < 16; i++) b[127-8*i -: 8] = 8'h00;
         b[7:0] = 8'(n);    // byte count in last byte
      end
      return b;
   endfunction

   function automatic logic [7:0] domain_of(input bit is_msg, input int n, input bit last);
      if (n < 16) return is_msg ? 8'd21 : 8'd26;
      if (last && n == 16) return is_msg ? 8'd20 : 8'd24;
      return is_msg ? 8'd4 : 8'd8;
   endfunction

   function automatic logic [31:0] keep_bytes(input logic [31:0] w, input int nb);
      logic [31:0] m;
      m = w;
      for (int b = nb; b < 4; b++) m[31-8*b -: 8] = 8'h00;
      return m;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("error: %s = %h, expected %h", name, got, exp);
         $display("test failed");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   task automatic build_inputs(input int adlen, input logic [3:0] ad_flags,
                               input int mlen, input logic [3:0] msg_flags);
      in_q.delete();
      in_q.push_back(32'h2000_0000);    // ENC
      in_q.push_back({4'h1, ad_flags, 8'h00, 16'(adlen)});
      for (int j = 0; j < (adlen + 3) / 4; j++) begin
         in_q.push_back({ad_bytes[4*j], ad_bytes[4*j+1], ad_bytes[4*j+2], ad_bytes[4*j+3]});
      end
      in_q.push_back(32'hD300_0010);
      for (int j = 0; j < 4; j++) in_q.push_back(nonce_m[127-32*j -: 32]);
      in_q.push_back({4'h4, msg_flags, 8'h00, 16'(mlen)});
      for (int j = 0; j < (mlen + 3) / 4; j++) begin
         in_q.push_back({msg_bytes[4*j], msg_bytes[4*j+1], msg_bytes[4*j+2], msg_bytes[4*j+3]});
      end
   endtask

   task automatic build_expected(input int adlen, input logic [3:0] ad_flags,
                                 input int mlen, input logic [3:0] msg_flags);
      logic [127:0] s;
      logic [127:0] raw;
      int           off;
      int           n;
      s   = '0;
      off = 0;
      do begin    // empty AD still absorbs one padded block
         n = adlen - off;
         s = s ^ pad_block(raw_block(1'b0, off), n) ^ {120'd0, domain_of(1'b0, n, ad_flags[1])};
         s = run_rounds(s, key_m);
         off += 16;
      end while (off < adlen);
      s = run_rounds(s ^ nonce_m, key_m);
      exp_q.delete();
      exp_q.push_back({4'h5, msg_flags, 8'h00, 16'(mlen)});
      for (off = 0; off < mlen; off += 16) begin
         n   = mlen - off;
         raw = raw_block(1'b1, off);
         for (int w = 0; w < 4; w++) begin
            if (4 * w < n) begin
               exp_q.push_back(keep_bytes(raw[127-32*w -: 32] ^ s[127-32*w -: 32], n - 4 * w));
            end
         end
         s = s ^ pad_block(raw, n) ^ {120'd0, domain_of(1'b1, n, msg_flags[1])};
         s = run_rounds(s, key_m);
      end
      exp_q.push_back(32'h8300_0010);
      for (int w = 0; w < 4; w++) exp_q.push_back(s[127-32*w -: 32]);
      exp_q.push_back(32'hE000_0000);
   endtask

   task automatic send_pdi(input logic [31:0] w);
      int gap;
      gap = rand_below(3);
      @(negedge clk);
      pdi_valid = 1'b0;
      repeat (gap) @(negedge clk);
      pdi_data  = w;
      pdi_valid = 1'b1;
      #1;
      while (!pdi_ready) begin
         @(negedge clk);
         #1;
      end
      @(posedge clk);    // word taken here
   endtask

   task automatic send_sdi(input logic [31:0] w);
      int gap;
      gap = rand_below(3);
      @(negedge clk);
      sdi_valid = 1'b0;
      repeat (gap) @(negedge clk);
      sdi_data  = w;
      sdi_valid = 1'b1;
      #1;
      while (!sdi_ready) begin
         @(negedge clk);
         #1;
      end
      @(posedge clk);
   endtask

   task automatic release_inputs();
      @(negedge clk);
      pdi_valid = 1'b0;
      sdi_valid = 1'b0;
   endtask

   task automatic load_key();
      for (int i = 0; i < 4; i++) key_m[127-32*i -: 32] = $random(seed);
      send_pdi(32'h7000_0000);    // ACTKEY
      release_inputs();
      send_sdi(32'h4000_0000);    // LDKEY
      send_sdi(32'hC300_0010);
      for (int i = 0; i < 4; i++) send_sdi(key_m[127-32*i -: 32]);
      release_inputs();
   endtask

   task automatic drive_pdi_stream();
      for (int i = 0; i < in_q.size(); i++) send_pdi(in_q[i]);
      release_inputs();
   endtask

   // every offered word is checked, so a stalled word must keep its value
   task automatic collect_outputs();
      int idx;
      idx = 0;
      while (idx < exp_q.size()) begin
         @(negedge clk);
         pdo_ready = (rand_below(4) != 0);
         #1;
         if (pdo_valid) begin
            check_value("pdo_data", pdo_data, exp_q[idx]);
            check_value("do_last", {31'd0, do_last}, 32'(idx == exp_q.size() - 1));
            if (pdo_ready) idx++;
         end
      end
   endtask

   initial begin
      int         adlen;
      int         mlen;
      logic [3:0] ad_flags;
      logic [3:0] msg_flags;
      seed        = 98;
      rst         = 1'b1;
      pdi_data    = '0;
      pdi_valid   = 1'b0;
      sdi_data    = '0;
      sdi_valid   = 1'b0;
      pdo_ready   = 1'b0;
      repeat (10) @(negedge clk);
      rst = 1'b0;
      #1;
      check_value("pdi_ready/sdi_ready/pdo_valid/do_last",
                  {28'd0, pdi_ready, sdi_ready, pdo_valid, do_last}, 32'd0);
      for (int r = 0; r < NUM_RUNS; r++) begin
         if (r == 0 || r == 9) load_key();
         if (r == 0) begin
            adlen = 0;
            mlen  = 16;
         end else if (r < 4) begin    // whole blocks only
            adlen = 16 * rand_below(3);
            mlen  = 16 * (1 + rand_below(2));
         end else if (r < 9) begin
            adlen = 1 + rand_below(40);
            mlen  = 1 + rand_below(40);
            if (adlen % 16 == 0) adlen--;
            if (mlen % 16 == 0) mlen--;
         end else begin
            adlen = rand_below(41);
            mlen  = 1 + rand_below(40);
         end
         ad_flags  = 4'h2 | 4'(rand_below(16) & 5);
         msg_flags = 4'h2 | 4'(rand_below(16) & 5);
         for (int i = 0; i < 48; i++) begin
            ad_bytes[i]  = 8'($random(seed));
            msg_bytes[i] = 8'($random(seed));
         end
         for (int i = 0; i < 4; i++) nonce_m[127-32*i -: 32] = $random(seed);
         build_inputs(adlen, ad_flags, mlen, msg_flags);
         build_expected(adlen, ad_flags, mlen, msg_flags);
         fork
            drive_pdi_stream();
            collect_outputs();
         join
      end
      $display("test passed");
      $finish;
   end

endmodule

`default_nettype wire

/* files.f */
+incdir+.
lwc_pkg.sv
lwc_api_ctrl.sv
lwc_state_core.sv
lwc_out_format.sv
lwc_api_top.sv
lwc_api_assertions.sv
lwc_api_tb.sv

/* run.sh */
#!/bin/sh
# build and run the lwc_api testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
   --top-module lwc_api_tb -f files.f -o lwc_api_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
   cat build.log
   echo "build failed with status $status"
   exit 1
fi

./obj_dir/lwc_api_sim > sim.log 2>&1
status=$?
cat sim.log

if grep -q "test failed" sim.log; then
   exit 1
fi
if [ $status -ne 0 ]; then
   echo "simulation ended with status $status"
   exit 1
fi
if ! grep -q "test passed" sim.log; then
   echo "simulation ended without a result"
   exit 1
fi
exit 0
